// ==== Makefile ====
TOP = tb_emu_core

all: run

obj_dir/V$(TOP): emu_core.f rtl/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -f emu_core.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f emu_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== emu_core.f ====
+incdir+sim
rtl/audio_pkg.sv
rtl/clock_cfg_pkg.sv
rtl/sample_mixer.sv
rtl/audio_compressor.sv
rtl/pll_reconfig_seq.sv
rtl/activity_led.sv
rtl/emu_core.sv
sim/tb_emu_core.sv

// ==== rtl/activity_led.sv ====
/*
 * Retriggerable lamp timer for one activity request
 */
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int HOLD_CYCLES = 4500000
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  req,
	output logic lamp
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// A new request always restarts the full hold time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
			lamp  <= 1'b0;
		end else begin
			lamp <= (count != '0);
			if (req) begin
				count <= CNT_W'(HOLD_CYCLES);
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/audio_compressor.sv ====
/*
 * Dynamic range compressor with two curves and a bypass, one register stage
 */
`timescale 1ns/1ps
`default_nettype none

module audio_compressor (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      mix_valid,
	input  wire audio_pkg::sample_t     mix_l,
	input  wire audio_pkg::sample_t     mix_r,
	input  wire audio_pkg::comp_mode_t  comp_mode,
	output logic                     audio_valid,
	output audio_pkg::sample_t       audio_l,
	output audio_pkg::sample_t       audio_r
);

	import audio_pkg::*;

	// Curve works on the magnitude, the sign is put back at the end
	function automatic sample_t compress(sample_t s, comp_mode_t mode);
		logic [15:0] mag;
		logic [15:0] v_light;
		logic [15:0] v_heavy;
		logic [15:0] v;

		mag = s[15] ? 16'(-s) : 16'(s);

		// Gain below the knee, slope 1/F above it
		if (mag < COMP_X1) begin
			v_light = mag * COMP_A1;
		end else begin
			v_light = ((mag - COMP_X1) / COMP_F1) + COMP_B1;
		end

		if (mag < COMP_X2) begin
			v_heavy = mag * COMP_A2;
		end else begin
			v_heavy = ((mag - COMP_X2) / COMP_F2) + COMP_B2;
		end

		// Bypass keeps the magnitude, so the sign restore gives the input back
		case (mode)
			COMP_LIGHT:   v = v_light;
			COMP_HEAVY_A: v = v_heavy;
			COMP_HEAVY_B: v = v_heavy;
			default:      v = mag;
		endcase

		return s[15] ? sample_t'(-v) : sample_t'(v);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output register, bypass goes through the same stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_valid <= 1'b0;
			audio_l     <= '0;
			audio_r     <= '0;
		end else begin
			audio_valid <= mix_valid;
			// Mode is taken as it stands when the mixed pair arrives
			if (mix_valid) begin
				audio_l <= compress(mix_l, comp_mode);
				audio_r <= compress(mix_r, comp_mode);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/audio_pkg.sv ====
/*
 * Audio sample types, compressor mode encoding and compressor curve constants
 */
`default_nettype none

package audio_pkg;

	// Signed PCM sample as it leaves the mixer and compressor
	typedef logic signed [15:0] sample_t;

	// One extra bit of headroom for the unclamped sum
	typedef logic signed [16:0] wide_sample_t;

	// Speaker volume step, each step doubles the pulse height
	typedef logic [1:0] spk_vol_t;

	// Compressor curve select
	typedef enum logic [1:0] {
		COMP_OFF     = 2'd0,
		COMP_LIGHT   = 2'd1,
		COMP_HEAVY_A = 2'd2,
		COMP_HEAVY_B = 2'd3
	} comp_mode_t;

	// Speaker pulse bit position at the lowest volume
	localparam int SPK_BASE_SHIFT = 11;

	//////////////////////////////////////////////////////////////////////
	// Light curve, factor 4 above the knee and gain 2 below it
	localparam logic [15:0] COMP_F1 = 16'd4;
	localparam logic [15:0] COMP_A1 = 16'd2;
	localparam logic [15:0] COMP_X1 = 16'd14044;
	localparam logic [15:0] COMP_B1 = 16'd28088;

	//////////////////////////////////////////////////////////////////////
	// Heavy curve, factor 8 above the knee and gain 4 below it
	localparam logic [15:0] COMP_F2 = 16'd8;
	localparam logic [15:0] COMP_A2 = 16'd4;
	localparam logic [15:0] COMP_X2 = 16'd7399;
	localparam logic [15:0] COMP_B2 = 16'd29596;

endpackage

`default_nettype wire

// ==== rtl/clock_cfg_pkg.sv ====
/*
 * Speed code type, PLL sequencer states, PLL register map and the
 * divider and clock-rate lookup tables
 */
`default_nettype none

package clock_cfg_pkg;

	// Bit 2 is overclock, bits 1:0 select the CPU speed
	typedef logic [2:0] speed_code_t;

	// Every write state is followed by a gap state
	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_WR_MODE,
		SEQ_GAP_MODE,
		SEQ_WR_CPU,
		SEQ_GAP_CPU,
		SEQ_WR_UART,
		SEQ_GAP_UART,
		SEQ_WR_START,
		SEQ_GAP_START
	} seq_state_t;

	//////////////////////////////////////////////////////////////////////
	// PLL reconfiguration register map
	localparam logic [5:0] PLL_REG_MODE  = 6'd0;
	localparam logic [5:0] PLL_REG_C_DIV = 6'd5;
	localparam logic [5:0] PLL_REG_START = 6'd2;

	// CPU output counter high/low settings per speed code
	localparam logic [17:0] CPU_DIV_TABLE [8] = '{
		18'h00505, 18'h01E1E, 18'h00F0F, 18'h00808,
		18'h20504, 18'h20504, 18'h20504, 18'h20504
	};

	// UART counter settings, slow class vs turbo class
	localparam logic [31:0] UART_DIV_LOW  = 32'h0004_F4F4;
	localparam logic [31:0] UART_DIV_HIGH = 32'h0004_0909;

	// Resulting CPU clock in Hz, all overclock codes run at 100 MHz
	localparam logic [27:0] CLK_RATE_TABLE [8] = '{
		28'd90000000, 28'd15000000, 28'd30000000, 28'd56250000,
		28'd100000000, 28'd100000000, 28'd100000000, 28'd100000000
	};

endpackage

`default_nettype wire

// ==== rtl/emu_core.sv ====
/*
 * Emulator glue top, audio output path, PLL reconfiguration and disk lamps
 */
`timescale 1ns/1ps
`default_nettype none

module emu_core #(
	parameter int LED_HOLD = 4500000
) (
	input  wire                          clk_sys,
	input  wire                          reset,

	// Audio sources, one strobe per sample pair
	input  wire                          sample_strobe,
	input  wire audio_pkg::sample_t         sb_l,
	input  wire audio_pkg::sample_t         sb_r,
	input  wire audio_pkg::sample_t         synth_l,
	input  wire audio_pkg::sample_t         synth_r,
	input  wire                          speaker,
	input  wire audio_pkg::spk_vol_t        spk_vol,
	input  wire                          synth_mute,
	input  wire audio_pkg::comp_mode_t      comp_mode,

	// Clock control
	input  wire clock_cfg_pkg::speed_code_t speed_code,
	input  wire                          uart_slow,
	input  wire                          pll_locked,
	input  wire                          cfg_waitrequest,

	input  wire [7:0]                    disk_req,

	output logic                         audio_valid,
	output audio_pkg::sample_t           audio_l,
	output audio_pkg::sample_t           audio_r,
	output logic                         cfg_write,
	output logic [5:0]                   cfg_address,
	output logic [31:0]                  cfg_data,
	output logic [27:0]                  clock_rate,
	output logic                         hdd_led,
	output logic                         fdd_led
);

	logic               mix_valid;
	audio_pkg::sample_t mix_l;
	audio_pkg::sample_t mix_r;
	logic               hdd_req;
	logic               fdd_req;

	////////////////////////////////////////////////////////////////////////
	// Audio
	sample_mixer mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sb_l          (sb_l),
		.sb_r          (sb_r),
		.synth_l       (synth_l),
		.synth_r       (synth_r),
		.speaker       (speaker),
		.spk_vol       (spk_vol),
		.synth_mute    (synth_mute),
		.mix_valid     (mix_valid),
		.mix_l         (mix_l),
		.mix_r         (mix_r)
	);

	audio_compressor compressor (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mix_valid   (mix_valid),
		.mix_l       (mix_l),
		.mix_r       (mix_r),
		.comp_mode   (comp_mode),
		.audio_valid (audio_valid),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	////////////////////////////////////////////////////////////////////////
	// PLL
	pll_reconfig_seq pll_seq (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.speed_code      (speed_code),
		.uart_slow       (uart_slow),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data),
		.clock_rate      (clock_rate)
	);

	////////////////////////////////////////////////////////////////////////
	// Disk lamps, IDE channels on 5:0 and floppies on 7:6
	assign hdd_req = |disk_req[5:0];
	assign fdd_req = |disk_req[7:6];

	activity_led #(.HOLD_CYCLES(LED_HOLD)) hdd_lamp (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (hdd_req),
		.lamp    (hdd_led)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) fdd_lamp (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (fdd_req),
		.lamp    (fdd_led)
	);

endmodule

`default_nettype wire

// ==== rtl/pll_reconfig_seq.sv ====
/*
 * PLL reconfiguration sequencer with wait-request handshake,
 * plus the current CPU clock rate register
 */
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_seq (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire clock_cfg_pkg::speed_code_t speed_code,
	input  wire                         uart_slow,
	input  wire                         pll_locked,
	input  wire                         cfg_waitrequest,
	output logic                        cfg_write,
	output logic [5:0]                  cfg_address,
	output logic [31:0]                 cfg_data,
	output logic [27:0]                 clock_rate
);

	import clock_cfg_pkg::*;

	seq_state_t  state;
	speed_code_t last_speed;
	logic        last_uart;
	logic        release_pend;
	logic        start_req;

	// Any change since the last idle sample, or a fresh reset release
	assign start_req = (speed_code != last_speed) || (uart_slow != last_uart) || release_pend;

	//////////////////////////////////////////////////////////////////////
	// Sequencer, frozen entirely while the config port stalls
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= SEQ_IDLE;
			cfg_write    <= 1'b0;
			last_speed   <= '0;
			last_uart    <= 1'b0;
			release_pend <= 1'b1;
		end else if (!cfg_waitrequest) begin
			cfg_write <= 1'b0;
			if (pll_locked) begin
				case (state)
					SEQ_IDLE: begin
						last_speed <= speed_code;
						last_uart  <= uart_slow;
						if (start_req) begin
							release_pend <= 1'b0;
							state        <= SEQ_WR_MODE;
						end
					end
					SEQ_WR_MODE: begin
						cfg_address <= PLL_REG_MODE;
						cfg_data    <= '0;
						cfg_write   <= 1'b1;
						state       <= SEQ_GAP_MODE;
					end
					SEQ_GAP_MODE:  state <= SEQ_WR_CPU;
					SEQ_WR_CPU: begin
						cfg_address <= PLL_REG_C_DIV;
						cfg_data    <= {14'd0, CPU_DIV_TABLE[last_speed]};
						cfg_write   <= 1'b1;
						state       <= SEQ_GAP_CPU;
					end
					SEQ_GAP_CPU:   state <= SEQ_WR_UART;
					SEQ_WR_UART: begin
						cfg_address <= PLL_REG_C_DIV;
						cfg_data    <= last_uart ? UART_DIV_LOW : UART_DIV_HIGH;
						cfg_write   <= 1'b1;
						state       <= SEQ_GAP_UART;
					end
					SEQ_GAP_UART:  state <= SEQ_WR_START;
					SEQ_WR_START: begin
						cfg_address <= PLL_REG_START;
						cfg_data    <= '0;
						cfg_write   <= 1'b1;
						state       <= SEQ_GAP_START;
					end
					SEQ_GAP_START: state <= SEQ_IDLE;
					default:       state <= SEQ_IDLE;
				endcase
			end
		end
	end

	// Rate seen by the core, tracks the request directly
	always_ff @(posedge clk_sys) begin
		clock_rate <= CLK_RATE_TABLE[speed_code];
	end

endmodule

`default_nettype wire

// ==== rtl/sample_mixer.sv ====
/*
 * Two-stage audio mixer, sums sound card, speaker and synth, then clamps
 */
`timescale 1ns/1ps
`default_nettype none

module sample_mixer (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   sample_strobe,
	input  wire audio_pkg::sample_t  sb_l,
	input  wire audio_pkg::sample_t  sb_r,
	input  wire audio_pkg::sample_t  synth_l,
	input  wire audio_pkg::sample_t  synth_r,
	input  wire                   speaker,
	input  wire audio_pkg::spk_vol_t spk_vol,
	input  wire                   synth_mute,
	output logic                  mix_valid,
	output audio_pkg::sample_t    mix_l,
	output audio_pkg::sample_t    mix_r
);

	import audio_pkg::*;

	wide_sample_t spk_term;
	wide_sample_t synth_term_l;
	wide_sample_t synth_term_r;
	wide_sample_t sum_l;
	wide_sample_t sum_r;
	logic         sum_valid;

	// Saturate when bits 16 and 15 disagree
	function automatic sample_t clamp_sum(wide_sample_t s);
		if (s[16] != s[15]) begin
			return {s[16], {15{~s[16]}}};
		end
		return s[15:0];
	endfunction

	// Speaker pulse moves up one bit per volume step
	assign spk_term = wide_sample_t'({16'd0, speaker} << (SPK_BASE_SHIFT + int'(spk_vol)));

	assign synth_term_l = synth_mute ? '0 : {synth_l[15], synth_l};
	assign synth_term_r = synth_mute ? '0 : {synth_r[15], synth_r};

	//////////////////////////////////////////////////////////////////////
	// Stage 1, raw sums
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= sample_strobe;
		end
		if (sample_strobe) begin
			sum_l <= {sb_l[15], sb_l} + spk_term + synth_term_l;
			sum_r <= {sb_r[15], sb_r} + spk_term + synth_term_r;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2, clamp to 16 bits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= sum_valid;
		end
		if (sum_valid) begin
			mix_l <= clamp_sum(sum_l);
			mix_r <= clamp_sum(sum_r);
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_models.svh ====
/*
 * Reference models for the mixer, the compressor curves,
 * the PLL write sequence and the clock-rate table
 */
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// Sound card plus speaker pulse plus unmuted synth, clamped to 16 bits
function automatic sample_t mix_model(sample_t sb, sample_t syn, logic spk, spk_vol_t vol,
		logic mute);
	int           sum;
	wide_sample_t wide;
	sum = int'(sb) + (mute ? 0 : int'(syn)) + (spk ? (1 << (SPK_BASE_SHIFT + int'(vol))) : 0);
	// The raw sum is carried in 17 bits before the clamp
	wide = 17'(sum);
	sum = int'(wide);
	sum = (sum > 32767) ? 32767 : ((sum < -32768) ? -32768 : sum);
	return sample_t'(sum);
endfunction

// Gain below the knee, excess over the knee divided by the factor above it
function automatic sample_t comp_model(sample_t s, comp_mode_t mode);
	int knee;
	int gain;
	int factor;
	int mag;
	int v;
	if (mode == COMP_OFF) begin
		return s;
	end
	knee   = (mode == COMP_LIGHT) ? int'(COMP_X1) : int'(COMP_X2);
	gain   = (mode == COMP_LIGHT) ? int'(COMP_A1) : int'(COMP_A2);
	factor = (mode == COMP_LIGHT) ? int'(COMP_F1) : int'(COMP_F2);
	mag    = (s < 0) ? -int'(s) : int'(s);
	// Upper segment starts at knee times gain
	v      = (mag < knee) ? mag * gain : (mag - knee) / factor + knee * gain;
	return (s < 0) ? sample_t'(-v) : sample_t'(v);
endfunction

// Address and data of write number idx, packed as {address, data}
function automatic logic [37:0] pll_write_model(int idx, speed_code_t code, logic slow);
	case (idx)
		0:       return {PLL_REG_MODE, 32'd0};
		1:       return {PLL_REG_C_DIV, 14'd0, CPU_DIV_TABLE[code]};
		2:       return {PLL_REG_C_DIV, slow ? UART_DIV_LOW : UART_DIV_HIGH};
		default: return {PLL_REG_START, 32'd0};
	endcase
endfunction

// CPU clock in Hz per speed code
function automatic logic [27:0] rate_model(speed_code_t code);
	case (code)
		3'd0:    return 28'd90_000_000;
		3'd1:    return 28'd15_000_000;
		3'd2:    return 28'd30_000_000;
		3'd3:    return 28'd56_250_000;
		default: return 28'd100_000_000;
	endcase
endfunction

`endif

// ==== sim/tb_emu_core.sv ====
/*
 * Testbench for emu_core, random audio mixing and compression,
 * PLL write sequences, clock-rate table and disk lamps
 */
`timescale 1ns/1ps
`default_nettype none

module tb_emu_core;

	import audio_pkg::*;
	import clock_cfg_pkg::*;

	`include "tb_models.svh"

	localparam int LED_HOLD = 40;
	// Sum of all test lengths with margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        sample_strobe;
	sample_t     sb_l, sb_r, synth_l, synth_r;
	logic        speaker;
	spk_vol_t    spk_vol;
	logic        synth_mute;
	comp_mode_t  comp_mode;
	speed_code_t speed_code;
	logic        uart_slow;
	logic        pll_locked;
	logic        cfg_waitrequest;
	logic [7:0]  disk_req;
	logic        audio_valid;
	sample_t     audio_l, audio_r;
	logic        cfg_write;
	logic [5:0]  cfg_address;
	logic [31:0] cfg_data;
	logic [27:0] clock_rate;
	logic        hdd_led;
	logic        fdd_led;

	// Error counts by area
	int          audio_errs = 0;
	int          port_errs = 0;
	int          rate_errs = 0;
	int          seq_errs = 0;
	int          lamp_errs = 0;
	int          flow_errs = 0;
	int          cycles = 0;
	string       phase_name = "none";
	logic [2:0]  strobe_hist;
	sample_t     exp_l_q[$];
	sample_t     exp_r_q[$];
	logic [37:0] wr_q[$];
	logic        prev_write;
	logic        prev_wait;
	logic [37:0] prev_wr;
	speed_code_t prev_speed;

	always #20 clk_sys = ~clk_sys;

	emu_core #(.LED_HOLD(LED_HOLD)) UUT (.*);

	//////////////////////////////////////////////////////////////////////
	// Audio scoreboard, each strobe's result is due three cycles later
	always @(posedge clk_sys) begin
		if (reset) begin
			strobe_hist <= '0;
		end else begin
			strobe_hist <= {strobe_hist[1:0], sample_strobe};
			assert (audio_valid == strobe_hist[2]) else begin
				$display("Output strobe is not three cycles after an input strobe");
				audio_errs++;
			end
			if (audio_valid && exp_l_q.size() > 0) begin
				assert (audio_l == exp_l_q[0] && audio_r == exp_r_q[0]) else begin
					$display("[FAIL] %s expected %0d/%0d actual %0d/%0d", phase_name,
						exp_l_q[0], exp_r_q[0], audio_l, audio_r);
					audio_errs++;
				end
				exp_l_q.delete(0);
				exp_r_q.delete(0);
			end
			if (sample_strobe) begin
				exp_l_q.push_back(comp_model(mix_model(sb_l, synth_l, speaker, spk_vol,
					synth_mute), comp_mode));
				exp_r_q.push_back(comp_model(mix_model(sb_r, synth_r, speaker, spk_vol,
					synth_mute), comp_mode));
			end
		end
	end

	// Logs taken PLL writes, checks the stalled port and the rate register
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (cfg_write && !cfg_waitrequest) begin
				wr_q.push_back({cfg_address, cfg_data});
			end
			if (prev_write && prev_wait) begin
				assert (cfg_write && {cfg_address, cfg_data} == prev_wr) else begin
					$display("PLL write dropped or changed while waitrequest was high");
					port_errs++;
				end
			end
			assert (clock_rate == rate_model(prev_speed)) else begin
				$display("[FAIL] clock_rate expected %0d actual %0d",
					rate_model(prev_speed), clock_rate);
				rate_errs++;
			end
		end
		prev_write <= cfg_write;
		prev_wait  <= cfg_waitrequest;
		prev_wr    <= {cfg_address, cfg_data};
		prev_speed <= speed_code;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Full-scale values come up often so the clamp gets exercised
	function automatic sample_t rand_sample();
		case ($urandom % 4)
			0:       return 16'sh7FFF;
			1:       return 16'sh8000;
			default: return sample_t'($urandom);
		endcase
	endfunction

	task automatic run_audio(string name, comp_mode_t mode, int count, logic force_mute);
		int   sent;
		int   guard;
		logic stb;
		sent = 0;
		guard = 0;
		phase_name = name;
		while (sent < count) begin
			@(posedge clk_sys);
			stb = ($urandom % 3) != 0;
			comp_mode     <= mode;
			sample_strobe <= stb;
			sb_l          <= rand_sample();
			sb_r          <= rand_sample();
			synth_l       <= rand_sample();
			synth_r       <= rand_sample();
			speaker       <= 1'($urandom);
			spk_vol       <= spk_vol_t'($urandom);
			synth_mute    <= force_mute || ($urandom % 4 == 0);
			if (stb) begin
				sent++;
			end
		end
		@(posedge clk_sys);
		sample_strobe <= 1'b0;
		while (exp_l_q.size() > 0 && guard < 10) begin
			@(posedge clk_sys);
			guard++;
		end
		assert (exp_l_q.size() == 0) else begin
			$display("Audio outputs missing at the end of %s", name);
			flow_errs++;
		end
	endtask

	// Waits for one full sequence with random wait-request, then for silence
	task automatic check_pll(string name, speed_code_t code, logic slow, int first);
		int guard;
		int i;
		guard = 0;
		while (wr_q.size() < first + 4 && guard < 300) begin
			@(posedge clk_sys);
			cfg_waitrequest <= 1'($urandom % 2);
			guard++;
		end
		repeat (30) begin
			@(posedge clk_sys);
			cfg_waitrequest <= 1'($urandom % 2);
		end
		assert (wr_q.size() - first == 4) else begin
			$display("[FAIL] %s write count expected 4 actual %0d", name, wr_q.size() - first);
			seq_errs++;
		end
		for (i = 0; i < 4 && first + i < wr_q.size(); i++) begin
			assert (wr_q[first + i] == pll_write_model(i, code, slow)) else begin
				$display("[FAIL] %s write %0d expected %h actual %h", name, i,
					pll_write_model(i, code, slow), wr_q[first + i]);
				seq_errs++;
			end
		end
	endtask

	// Runs a window with random wait-request in which no write may be taken
	task automatic check_no_writes(string name, int window);
		int first;
		first = wr_q.size();
		repeat (window) begin
			@(posedge clk_sys);
			cfg_waitrequest <= 1'($urandom % 2);
		end
		assert (wr_q.size() == first) else begin
			$display("[FAIL] %s write count expected 0 actual %0d", name, wr_q.size() - first);
			seq_errs++;
		end
	endtask

	task automatic check_lamp(int bit_idx, int retrig);
		logic       use_hdd;
		logic       done;
		logic [7:0] pat;
		int         lit;
		int         expect_lit;
		int         i;
		pat = 8'(1 << bit_idx);
		use_hdd = bit_idx < 6;
		done = 1'b0;
		lit = 0;
		// A second request lands retrig + 2 cycles after the first
		expect_lit = (retrig > 0) ? LED_HOLD + retrig + 2 : LED_HOLD;
		@(posedge clk_sys);
		disk_req <= pat;
		@(posedge clk_sys);
		disk_req <= '0;
		for (i = 0; i < 200 && !done; i++) begin
			@(posedge clk_sys);
			disk_req <= (retrig > 0 && i == retrig) ? pat : 8'd0;
			assert (use_hdd ? !fdd_led : !hdd_led) else begin
				$display("Wrong lamp lit for request bit %0d", bit_idx);
				lamp_errs++;
			end
			if (use_hdd ? hdd_led : fdd_led) begin
				lit++;
			end else if (lit > 0) begin
				done = 1'b1;
			end
		end
		assert (done && lit >= expect_lit - 1 && lit <= expect_lit + 1) else begin
			$display("[FAIL] lamp_bit%0d expected %0d actual %0d", bit_idx, expect_lit, lit);
			lamp_errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		speed_code_t new_code;
		logic        new_slow;
		void'($urandom(32));
		reset = 1'b1;
		sample_strobe = 1'b0;
		sb_l = '0;
		sb_r = '0;
		synth_l = '0;
		synth_r = '0;
		speaker = 1'b0;
		spk_vol = '0;
		synth_mute = 1'b0;
		comp_mode = COMP_OFF;
		// Same values as the cleared history, only the release starts a sequence
		speed_code = 3'd0;
		uart_slow = 1'b0;
		pll_locked = 1'b1;
		cfg_waitrequest = 1'b0;
		disk_req = '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		assert (!audio_valid && audio_l == '0 && audio_r == '0 && !cfg_write && !hdd_led
			&& !fdd_led) else begin
			$display("Outputs are not cleared by reset");
			flow_errs++;
		end
		check_pll("pll_release", 3'd0, 1'b0, 0);
		repeat (6) begin
			new_code = speed_code;
			new_slow = uart_slow;
			if ($urandom % 2) begin
				new_code = speed_code ^ speed_code_t'(1 + $urandom % 7);
			end else begin
				new_slow = !uart_slow;
			end
			@(posedge clk_sys);
			speed_code <= new_code;
			uart_slow  <= new_slow;
			check_pll("pll_change", new_code, new_slow, wr_q.size());
		end

		// No writes while the PLL is unlocked, the sequence follows the lock
		new_code = ~speed_code;
		@(posedge clk_sys);
		pll_locked <= 1'b0;
		speed_code <= new_code;
		check_no_writes("pll_unlocked", 40);
		@(posedge clk_sys);
		pll_locked <= 1'b1;
		check_pll("pll_relock", new_code, uart_slow, wr_q.size());

		run_audio("mix_clamp", COMP_OFF, 300, 1'b0);
		run_audio("comp_light", COMP_LIGHT, 100, 1'b0);
		run_audio("comp_heavy_a", COMP_HEAVY_A, 100, 1'b0);
		run_audio("comp_heavy_b", COMP_HEAVY_B, 100, 1'b0);
		run_audio("synth_mute", COMP_OFF, 60, 1'b1);

		repeat (4) check_lamp($urandom % 8, 0);
		repeat (2) check_lamp($urandom % 8, 20);

		repeat (5) @(posedge clk_sys);
		$display("Errors: audio %0d, pll port %0d, rate %0d, pll sequence %0d, lamp %0d, flow %0d",
			audio_errs, port_errs, rate_errs, seq_errs, lamp_errs, flow_errs);
		if (audio_errs + port_errs + rate_errs + seq_errs + lamp_errs + flow_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
